//--- common/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// cpu side widths
`define ADDR_WIDTH 32
`define WORD_WIDTH 32

// ram data bus is one byte wide
`define BYTE_WIDTH 8

// bytes per word, also the fetch length
`define WORD_BYTES 4

// byte count runs 0..WORD_BYTES
`define LEN_WIDTH 3

`endif

//--- common/ramBusPkg.sv
`include "mem_params.svh"

package ramBusPkg;

    // direction of the single ram port
    typedef enum logic {
        MemRead  = 1'b0,
        MemWrite = 1'b1
    } memRwT;

    // one byte on the ram data bus
    typedef logic [`BYTE_WIDTH-1:0] byteT;

endpackage

//--- common/memCtrlPkg.sv
`include "mem_params.svh"

package memCtrlPkg;

    // operation currently owned by the controller
    typedef enum logic [1:0] {
        KindFetch = 2'd0,
        KindLoad  = 2'd1,
        KindStore = 2'd2
    } accessKindT;

    // arbiter FSM
    typedef enum logic [1:0] {
        ArbIdle    = 2'd0,
        ArbBusy    = 2'd1,
        ArbRelease = 2'd2
    } arbStateT;

    // byte count of one access
    typedef logic [`LEN_WIDTH-1:0] lenT;

endpackage

//--- common/memReqIf.sv
`timescale 1ns/1ps
`include "mem_params.svh"

interface memReqIf
    import memCtrlPkg::*;
();
    // launch of one access, operands stay stable until done
    logic                   start;
    accessKindT             kind;
    logic [`ADDR_WIDTH-1:0] addr;
    lenT                    len;
    logic [`WORD_WIDTH-1:0] wdata;

    // global freeze, owned by the arbiter
    logic                   hold;

    // completion back from the sequencer
    logic                   done;
    logic [`WORD_WIDTH-1:0] rdata;

    modport arbiter (
        output start,
        output kind,
        output addr,
        output len,
        output wdata,
        output hold,
        input  done
    );

    modport sequencer (
        input  start,
        input  kind,
        input  addr,
        input  len,
        input  wdata,
        input  hold,
        output done,
        output rdata
    );

endinterface

//--- memArbiter/memArbiter.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module memArbiter
    import memCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull,

    input  logic                   i_instEn,
    input  logic [`ADDR_WIDTH-1:0] i_instAddr,

    input  logic                   i_dataEn,
    input  logic                   i_dataWrite,
    input  lenT                    i_dataLen,
    input  logic [`ADDR_WIDTH-1:0] i_dataAddr,
    input  logic [`WORD_WIDTH-1:0] i_dataWdata,

    output logic                   o_instDone,
    output logic                   o_dataDone,

    memReqIf.arbiter               req
);

    arbStateT               state;
    accessKindT             kindReg;
    accessKindT             nextKind;
    logic [`ADDR_WIDTH-1:0] addrReg;
    lenT                    lenReg;
    logic [`WORD_WIDTH-1:0] wdataReg;
    logic                   hold;
    logic                   anyReq;

    assign hold   = !i_rdy || i_ioBufferFull;
    assign anyReq = i_dataEn || i_instEn;

    // data side wins over fetch
    always_comb begin
        if (i_dataEn) begin
            nextKind = i_dataWrite ? KindStore : KindLoad;
        end else begin
            nextKind = KindFetch;
        end
    end

    assign req.start = (state == ArbIdle) && anyReq && !hold;
    assign req.hold  = hold;
    assign req.kind  = kindReg;
    assign req.addr  = addrReg;
    assign req.len   = lenReg;
    assign req.wdata = wdataReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ArbIdle;
            kindReg <= KindFetch;
        end else if (!hold) begin
            case (state)
                ArbIdle: begin
                    if (req.start) begin
                        state   <= ArbBusy;
                        kindReg <= nextKind;
                    end
                end
                ArbBusy: begin
                    if (req.done) begin
                        state <= ArbRelease;
                    end
                end
                // lets a requester drop its enable before the next accept
                ArbRelease: begin
                    state <= ArbIdle;
                end
                default: begin
                    state <= ArbIdle;
                end
            endcase
        end
    end

    // operands latched once at accept
    always_ff @(posedge clk) begin
        if (req.start) begin
            addrReg  <= i_dataEn ? i_dataAddr : i_instAddr;
            lenReg   <= i_dataEn ? i_dataLen : lenT'(`WORD_BYTES);
            wdataReg <= i_dataWdata;
        end
    end

    assign o_instDone = req.done && (kindReg == KindFetch);
    assign o_dataDone = req.done && (kindReg != KindFetch);

    // an accepted request leaves idle with the winner recorded
    startAccepts: assert property (@(posedge clk) disable iff (rst)
        req.start |=> state == ArbBusy && kindReg == $past(nextKind));

    // sequencer may only finish an access the arbiter handed out
    doneOnlyBusy: assert property (@(posedge clk) disable iff (rst)
        req.done |-> state == ArbBusy);

    oneDone: assert property (@(posedge clk) disable iff (rst)
        $onehot0({o_instDone, o_dataDone}));

endmodule

//--- byteSequencer/byteSequencer.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module byteSequencer
    import ramBusPkg::*;
    import memCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  byteT                   i_memRdata,
    output memRwT                  o_memRw,
    output logic [`ADDR_WIDTH-1:0] o_memAddr,
    output byteT                   o_memWdata,
    memReqIf.sequencer             req
);

    logic                   busy;
    lenT                    issueCnt;
    lenT                    capCnt;
    logic                   pending;
    logic [`WORD_WIDTH-1:0] word;
    logic                   isStore;
    logic                   issuing;
    logic                   complete;
    logic [5:0]             alignShift;

    assign isStore = (req.kind == KindStore);
    assign issuing = busy && (issueCnt < req.len);

    // store ends after its last write edge, read after its last capture
    assign complete = busy && (isStore ? (issueCnt == req.len) : (capCnt == req.len));
    assign req.done = complete && !req.hold;

    assign o_memAddr  = req.addr + {{(`ADDR_WIDTH - `LEN_WIDTH){1'b0}}, issueCnt};
    assign o_memWdata = req.wdata[issueCnt[1:0] * `BYTE_WIDTH +: `BYTE_WIDTH];
    assign o_memRw    = (isStore && issuing && !req.hold) ? MemWrite : MemRead;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            issueCnt <= '0;
            capCnt   <= '0;
            pending  <= 1'b0;
        end else if (req.start) begin
            busy     <= 1'b1;
            issueCnt <= '0;
            capCnt   <= '0;
            pending  <= 1'b0;
        end else if (req.done) begin
            busy    <= 1'b0;
            pending <= 1'b0;
        end else begin
            // a held issue is not counted, so the same address goes out again
            pending <= issuing && !req.hold && !isStore;
            if (issuing && !req.hold) begin
                issueCnt <= issueCnt + 1'b1;
            end
            // byte is on the bus only this cycle
            if (pending) begin
                capCnt <= capCnt + 1'b1;
            end
        end
    end

    // low byte arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (req.start) begin
            word <= '0;
        end else if (pending) begin
            word <= {i_memRdata, word[`WORD_WIDTH-1:`BYTE_WIDTH]};
        end
    end

    // short loads sit in the upper bytes until aligned down
    assign alignShift = 6'((`WORD_BYTES - req.len) * `BYTE_WIDTH);
    assign req.rdata  = word >> alignShift;

    // a held cycle keeps the address for the reissue
    addrHeldInHold: assert property (@(posedge clk) disable iff (rst)
        busy && req.hold |=> o_memAddr == $past(o_memAddr));

    issueBound: assert property (@(posedge clk) disable iff (rst)
        busy |-> issueCnt <= req.len);

endmodule

//--- design/memCtrl.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module memCtrl
    import ramBusPkg::*;
    import memCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // instruction fetch
    input  logic                   i_instEn,
    input  logic [`ADDR_WIDTH-1:0] i_instAddr,
    output logic                   o_instDone,
    output logic [`WORD_WIDTH-1:0] o_instWord,

    // load/store unit
    input  logic                   i_dataEn,
    input  logic                   i_dataWrite,
    input  lenT                    i_dataLen,
    input  logic [`ADDR_WIDTH-1:0] i_dataAddr,
    input  logic [`WORD_WIDTH-1:0] i_dataWdata,
    output logic                   o_dataDone,
    output logic [`WORD_WIDTH-1:0] o_dataRdata,

    // byte wide ram
    output memRwT                  o_memRw,
    output logic [`ADDR_WIDTH-1:0] o_memAddr,
    output byteT                   o_memWdata,
    input  byteT                   i_memRdata,

    // freeze sources
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull
);

    memReqIf req ();

    memArbiter uArbiter (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_instEn       (i_instEn),
        .i_instAddr     (i_instAddr),
        .i_dataEn       (i_dataEn),
        .i_dataWrite    (i_dataWrite),
        .i_dataLen      (i_dataLen),
        .i_dataAddr     (i_dataAddr),
        .i_dataWdata    (i_dataWdata),
        .o_instDone     (o_instDone),
        .o_dataDone     (o_dataDone),
        .req            (req.arbiter)
    );

    byteSequencer uSequencer (
        .clk        (clk),
        .rst        (rst),
        .i_memRdata (i_memRdata),
        .o_memRw    (o_memRw),
        .o_memAddr  (o_memAddr),
        .o_memWdata (o_memWdata),
        .req        (req.sequencer)
    );

    // same word to both sides, only the owner's done qualifies it
    assign o_instWord  = req.rdata;
    assign o_dataRdata = req.rdata;

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic o_clk,
    output logic o_rst
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // reset held for four rising edges
    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

//--- tests/memCtrlTb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module memCtrlTb
    import ramBusPkg::*;
    import memCtrlPkg::*;
();

    localparam int RamDepth      = 4096;
    localparam int MaxSteps      = 20;
    localparam int TimeoutCycles = 200;
    localparam int IdleCycles    = 8;

    typedef struct packed {
        accessKindT             kind;
        logic [11:0]            addr;
        lenT                    len;
        logic                   withFetch;
        logic                   stall;
        logic [`WORD_WIDTH-1:0] wdata;
        logic [`WORD_WIDTH-1:0] expected;
        logic [`WORD_WIDTH-1:0] expFetch;
    } stepT;

    logic                   clk;
    logic                   rst;
    logic                   instEn;
    logic [`ADDR_WIDTH-1:0] instAddr;
    logic                   instDone;
    logic [`WORD_WIDTH-1:0] instWord;
    logic                   dataEn;
    logic                   dataWrite;
    lenT                    dataLen;
    logic [`ADDR_WIDTH-1:0] dataAddr;
    logic [`WORD_WIDTH-1:0] dataWdata;
    logic                   dataDone;
    logic [`WORD_WIDTH-1:0] dataRdata;
    memRwT                  memRw;
    logic [`ADDR_WIDTH-1:0] memAddr;
    byteT                   memWdata;
    byteT                   memRdata = '0;
    logic                   rdy;
    logic                   ioBufferFull;

    byteT        ram [RamDepth];
    byteT        shadow [RamDepth];
    stepT        steps [MaxSteps];
    string       stepName [MaxSteps];
    int          stepCount;
    int          errorCount;
    int          failedTests;
    bit          timedOut;
    bit          stallOn;
    logic [31:0] seed;

    clockGen uClock (
        .o_clk (clk),
        .o_rst (rst)
    );

    memCtrl dut (
        .clk            (clk),
        .rst            (rst),
        .i_instEn       (instEn),
        .i_instAddr     (instAddr),
        .o_instDone     (instDone),
        .o_instWord     (instWord),
        .i_dataEn       (dataEn),
        .i_dataWrite    (dataWrite),
        .i_dataLen      (dataLen),
        .i_dataAddr     (dataAddr),
        .i_dataWdata    (dataWdata),
        .o_dataDone     (dataDone),
        .o_dataRdata    (dataRdata),
        .o_memRw        (memRw),
        .o_memAddr      (memAddr),
        .o_memWdata     (memWdata),
        .i_memRdata     (memRdata),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull)
    );

    // byte wide ram, read data one cycle after the address
    always @(posedge clk) begin
        if (memRw == MemWrite) begin
            ram[memAddr[11:0]] <= memWdata;
        end
        memRdata <= ram[memAddr[11:0]];
    end

    // a frozen controller must not write
    always @(posedge clk) begin
        if (!rst && (!rdy || ioBufferFull) && memRw == MemWrite) begin
            $display("RAM write to address %h while the controller was held", memAddr);
            errorCount++;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // little endian view of the expected memory
    function automatic logic [31:0] modelRead(input logic [11:0] addr, input int len);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < len; i++) begin
            word[i*8 +: 8] = shadow[12'(addr + i)];
        end
        return word;
    endfunction

    function automatic void addStep(input string name, input accessKindT kind,
                                    input logic [11:0] addr, input lenT len,
                                    input logic withFetch, input logic stall);
        stepT s;
        s.kind      = kind;
        s.addr      = addr;
        s.len       = (kind == KindFetch) ? lenT'(`WORD_BYTES) : len;
        s.withFetch = withFetch;
        s.stall     = stall;
        s.wdata     = '0;
        s.expected  = modelRead(addr, int'(s.len));
        s.expFetch  = modelRead(12'(addr + 12'h200), `WORD_BYTES);
        if (kind == KindStore) begin
            seed     = xorshift(seed);
            s.wdata  = seed;
            s.expected = '0;
            // low byte first at consecutive addresses
            for (int i = 0; i < int'(s.len); i++) begin
                shadow[12'(addr + i)] = seed[i*8 +: 8];
            end
        end
        steps[stepCount]    = s;
        stepName[stepCount] = name;
        stepCount++;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic driveHold(input bit finished);
        if (stallOn && !finished) begin
            seed = xorshift(seed);
            rdy          <= seed[0] | seed[1];
            ioBufferFull <= seed[2] & seed[3];
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    endtask

    task automatic waitDone(input bit wantData, input string name,
                            output bit seen, output logic [31:0] word);
        int cycles;
        seen   = 1'b0;
        word   = '0;
        cycles = 0;
        while (!seen && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
            if (wantData ? dataDone : instDone) begin
                seen = 1'b1;
                word = wantData ? dataRdata : instWord;
            end else if (wantData && instDone) begin
                $display("%s: fetch finished before the data access", name);
                errorCount++;
            end
            driveHold(seen);
        end
        if (!seen) begin
            $display("%s: no done pulse within %0d cycles", name, TimeoutCycles);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic runStep(input int idx);
        stepT        s;
        logic [31:0] word;
        bit          seen;
        int          errorsBefore;
        s            = steps[idx];
        errorsBefore = errorCount;
        stallOn      = s.stall;
        if (s.kind == KindFetch) begin
            instAddr <= 32'(s.addr);
            instEn   <= 1'b1;
            waitDone(1'b0, stepName[idx], seen, word);
            instEn <= 1'b0;
            if (seen) begin
                checkValue(stepName[idx], s.expected, word);
            end
        end else begin
            dataAddr  <= 32'(s.addr);
            dataLen   <= s.len;
            dataWrite <= (s.kind == KindStore);
            dataWdata <= s.wdata;
            dataEn    <= 1'b1;
            if (s.withFetch) begin
                instAddr <= 32'(s.addr) + 32'h200;
                instEn   <= 1'b1;
            end
            waitDone(1'b1, stepName[idx], seen, word);
            dataEn <= 1'b0;
            if (seen && s.kind != KindStore) begin
                checkValue(stepName[idx], s.expected, word);
            end
            // fetch is served only after the data side
            if (seen && s.withFetch) begin
                waitDone(1'b0, stepName[idx], seen, word);
                instEn <= 1'b0;
                if (seen) begin
                    checkValue({stepName[idx], " fetch"}, s.expFetch, word);
                end
            end
        end
        if (errorCount != errorsBefore) begin
            failedTests++;
        end
        $display("%s: %s", stepName[idx], (errorCount == errorsBefore) ? "passed" : "failed");
    endtask

    initial begin
        int cycles;
        int errorsBefore;
        instEn       = 1'b0;
        instAddr     = '0;
        dataEn       = 1'b0;
        dataWrite    = 1'b0;
        dataLen      = '0;
        dataAddr     = '0;
        dataWdata    = '0;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        errorCount   = 0;
        failedTests  = 0;
        stepCount    = 0;
        timedOut     = 1'b0;
        stallOn      = 1'b0;
        seed         = 32'hcd26_37b6;

        for (int a = 0; a < RamDepth; a++) begin
            seed      = xorshift(seed);
            ram[a]    = seed[7:0];
            shadow[a] = seed[7:0];
        end

        addStep("fetch aligned", KindFetch, 12'h010, 3'd4, 1'b0, 1'b0);
        addStep("fetch unaligned", KindFetch, 12'h123, 3'd4, 1'b0, 1'b0);
        addStep("load byte", KindLoad, 12'h040, 3'd1, 1'b0, 1'b0);
        addStep("load half", KindLoad, 12'h041, 3'd2, 1'b0, 1'b0);
        addStep("load word", KindLoad, 12'h043, 3'd4, 1'b0, 1'b0);
        addStep("store byte", KindStore, 12'h080, 3'd1, 1'b0, 1'b0);
        addStep("check byte", KindLoad, 12'h080, 3'd4, 1'b0, 1'b0);
        addStep("store half", KindStore, 12'h0a1, 3'd2, 1'b0, 1'b0);
        addStep("check half", KindLoad, 12'h0a0, 3'd4, 1'b0, 1'b0);
        addStep("store word", KindStore, 12'h0c2, 3'd4, 1'b0, 1'b0);
        addStep("check word", KindLoad, 12'h0c0, 3'd4, 1'b0, 1'b0);
        addStep("load and fetch", KindLoad, 12'h300, 3'd4, 1'b1, 1'b0);
        addStep("both stalled", KindLoad, 12'h311, 3'd2, 1'b1, 1'b1);
        addStep("fetch stalled", KindFetch, 12'h600, 3'd4, 1'b0, 1'b1);
        addStep("store stalled", KindStore, 12'h700, 3'd4, 1'b0, 1'b1);
        addStep("check stalled", KindLoad, 12'h6fe, 3'd4, 1'b0, 1'b1);
        addStep("load stalled", KindLoad, 12'h702, 3'd1, 1'b0, 1'b1);

        cycles = 0;
        while (rst && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            $display("reset was never released");
            errorCount++;
            timedOut = 1'b1;
        end

        // idle controller after reset
        errorsBefore = errorCount;
        for (int c = 0; c < IdleCycles && !timedOut; c++) begin
            @(posedge clk);
            checkValue("reset idle done", 32'd0, {30'd0, instDone, dataDone});
            checkValue("reset idle rw", 32'(MemRead), 32'(memRw));
        end
        if (errorCount != errorsBefore) begin
            failedTests++;
        end
        $display("reset idle: %s", (errorCount == errorsBefore) ? "passed" : "failed");

        for (int i = 0; i < stepCount && !timedOut; i++) begin
            @(posedge clk);
            runStep(i);
        end

        $display("tests %0d, failed %0d, errors %0d", stepCount + 1, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/ramBusPkg.sv
common/memCtrlPkg.sv
common/memReqIf.sv
memArbiter/memArbiter.sv
byteSequencer/byteSequencer.sv
design/memCtrl.sv
tests/clockGen.sv
tests/memCtrlTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = memCtrlTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = TEST OK

SOURCES   = $(shell grep -v '^+' $(FILELIST))
HEADERS   = $(wildcard common/*.svh)
BINARY    = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
